/* Makefile */
VERILATOR ?= verilator
TOP       := tb_spu_alu
FILELIST  := spu_alu.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) spu_alu_settings.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* fp_lane.sv */
`timescale 1ns/1ps
`include "spu_alu_settings.svh"

module fp_lane
  import spu_alu_pkg::*;
(
  input  op_e                    op,
  input  logic [`SPU_WORD_W-1:0] a,
  input  logic [`SPU_WORD_W-1:0] b,
  input  logic [`SPU_WORD_W-1:0] c,
  output logic [`SPU_WORD_W-1:0] y
);

  // sum field, carry bit, 48 bit mantissa, two guard bits.
  localparam int FW = 51;

  logic                   is_mul;
  logic                   neg_p;
  logic                   neg_d;
  logic [7:0]             a_e;
  logic [7:0]             b_e;
  logic [23:0]            a_m;
  logic [23:0]            b_m;
  logic [47:0]            prod;
  logic [`SPU_WORD_W-1:0] d_word;
  logic                   p_zero;
  logic                   p_s;
  logic signed [11:0]     p_e;
  logic [47:0]            p_m;
  logic                   q_zero;
  logic                   q_s;
  logic signed [11:0]     q_e;
  logic [47:0]            q_m;
  logic                   big_s;
  logic signed [11:0]     big_e;
  logic [FW-1:0]          big_f;
  logic                   sml_s;
  logic [FW-1:0]          sml_f;
  logic signed [11:0]     dif;
  logic [5:0]             sh;
  logic [FW-1:0]          sml_sh;
  logic                   sticky;
  logic [FW:0]            sum;
  logic [FW:0]            neg_sum;
  logic [FW-1:0]          mag;
  logic                   r_s;
  logic [5:0]             lead;
  logic [FW-1:0]          norm;
  logic signed [11:0]     r_e;

  assign is_mul = (op == op_fm) || (op == op_fma) || (op == op_fms) || (op == op_fnms);
  assign neg_p  = (op == op_fnms);
  assign neg_d  = (op == op_fs) || (op == op_fms);
  assign d_word = ((op == op_fa) || (op == op_fs)) ? b : c;

  // exponent 0 reads as zero.
  assign a_e  = a[30:23];
  assign b_e  = b[30:23];
  assign a_m  = (a_e == 8'd0) ? 24'd0 : {1'b1, a[22:0]};
  assign b_m  = (b_e == 8'd0) ? 24'd0 : {1'b1, b[22:0]};
  assign prod = {24'd0, a_m} * {24'd0, b_m};

  ////////////////////////////////////////////////////////////
  // product and addend terms, leading one at bit 47.
  ////////////////////////////////////////////////////////////
  always_comb begin
    if (is_mul) begin
      p_zero = (a_e == 8'd0) || (b_e == 8'd0);
      p_s    = a[31] ^ b[31] ^ neg_p;
      if (prod[47]) begin
        p_m = prod;
        p_e = $signed({4'd0, a_e}) + $signed({4'd0, b_e}) - 12'sd126;
      end else begin
        p_m = prod << 1;
        p_e = $signed({4'd0, a_e}) + $signed({4'd0, b_e}) - 12'sd127;
      end
    end else begin
      // fa and fs, a times 1.0.
      p_zero = (a_e == 8'd0);
      p_s    = a[31];
      p_m    = {a_m, 24'd0};
      p_e    = $signed({4'd0, a_e});
    end
  end

  assign q_zero = (d_word[30:23] == 8'd0) || (op == op_fm);
  assign q_s    = d_word[31] ^ neg_d;
  assign q_e    = $signed({4'd0, d_word[30:23]});
  assign q_m    = q_zero ? 48'd0 : {1'b1, d_word[22:0], 24'd0};

  ////////////////////////////////////////////////////////////
  // align, exact add with sticky borrow.
  ////////////////////////////////////////////////////////////
  always_comb begin
    if (q_zero || (!p_zero && (p_e >= q_e))) begin
      big_s = p_s;
      big_e = p_e;
      big_f = {1'b0, p_m, 2'b00};
      sml_s = q_s;
      sml_f = {1'b0, q_m, 2'b00};
      dif   = p_e - q_e;
    end else begin
      big_s = q_s;
      big_e = q_e;
      big_f = {1'b0, q_m, 2'b00};
      sml_s = p_s;
      sml_f = {1'b0, p_m, 2'b00};
      dif   = q_e - p_e;
    end
    sh     = (dif > 12'sd51) ? 6'd51 : dif[5:0];
    sml_sh = sml_f >> sh;
    sticky = |(sml_f & ~({FW{1'b1}} << sh));
    // shifted-out bits lower a difference, never a sum.
    if (big_s ^ sml_s) begin
      sum = {1'b0, big_f} - {1'b0, sml_sh} - {{FW{1'b0}}, sticky};
    end else begin
      sum = {1'b0, big_f} + {1'b0, sml_sh};
    end
    neg_sum = ~sum + 1'b1;
    mag     = sum[FW] ? neg_sum[FW-1:0] : sum[FW-1:0];
    r_s     = big_s ^ sum[FW];
  end

  ////////////////////////////////////////////////////////////
  // normalise, truncate, flush and saturate.
  ////////////////////////////////////////////////////////////
  always_comb begin
    lead = 6'd0;
    for (int i = 0; i < FW; i++) begin
      if (mag[i]) lead = i[5:0];
    end
    norm = mag << (6'(FW - 1) - lead);
    r_e  = big_e + $signed({6'd0, lead}) - 12'sd49;
    if ((mag == '0) || (r_e < 12'sd1)) begin
      y = '0;
    end else if (r_e > 12'sd255) begin
      y = {r_s, 8'hff, 23'h7fffff};
    end else begin
      y = {r_s, r_e[7:0], norm[FW-2 -: 23]};
    end
  end

endmodule

/* mpy_lane.sv */
`timescale 1ns/1ps
`include "spu_alu_settings.svh"

module mpy_lane
  import spu_alu_pkg::*;
(
  input  op_e                    op,
  input  logic [`SPU_WORD_W-1:0] a,
  input  logic [`SPU_WORD_W-1:0] b,
  input  logic [`SPU_WORD_W-1:0] c,
  input  logic [9:0]             imm10,
  output logic [`SPU_WORD_W-1:0] y
);

  logic [15:0] imm_x;
  logic [31:0] a_lo_s;
  logic [31:0] b_lo_s;
  logic [31:0] a_lo_u;
  logic [31:0] b_lo_u;
  logic [31:0] a_hi_u;
  logic [31:0] imm_s;
  logic [31:0] imm_u;

  // extended operands, low 32 bits of the product are all that is kept.
  assign imm_x  = {{6{imm10[9]}}, imm10};
  assign a_lo_s = {{16{a[15]}}, a[15:0]};
  assign b_lo_s = {{16{b[15]}}, b[15:0]};
  assign a_lo_u = {16'd0, a[15:0]};
  assign b_lo_u = {16'd0, b[15:0]};
  assign a_hi_u = {16'd0, a[31:16]};
  assign imm_s  = {{16{imm_x[15]}}, imm_x};
  assign imm_u  = {16'd0, imm_x};

  always_comb begin
    case (op)
      op_mpy:   y = a_lo_s * b_lo_s;
      op_mpyu:  y = a_lo_u * b_lo_u;
      op_mpyh:  y = (a_hi_u * b_lo_u) << 16;
      op_mpyi:  y = a_lo_s * imm_s;
      op_mpyui: y = a_lo_u * imm_u;
      op_mpya:  y = (a_lo_s * b_lo_s) + c;
      default:  y = '0;
    endcase
  end

endmodule

/* sp_alu.sv */
`timescale 1ns/1ps
`include "spu_alu_settings.svh"

module sp_alu
  import spu_alu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     start,
  input  alu_req_t req,
  output quad_t    result,
  output logic     done
);

  quad_t fp_y;
  quad_t mp_y;
  quad_t sel;

  // same op in every slot.
  for (genvar i = 0; i < `SPU_SLOTS; i++) begin : g_slot
    fp_lane u_fp (
      .op (req.op),
      .a  (req.ra[i]),
      .b  (req.rb[i]),
      .c  (req.rc[i]),
      .y  (fp_y[i])
    );

    mpy_lane u_mpy (
      .op    (req.op),
      .a     (req.ra[i]),
      .b     (req.rb[i]),
      .c     (req.rc[i]),
      .imm10 (req.imm10),
      .y     (mp_y[i])
    );
  end

  always_comb begin
    case (req.op)
      op_fa, op_fs, op_fm, op_fma, op_fms, op_fnms: sel = fp_y;
      op_mpy, op_mpyu, op_mpyh, op_mpyi, op_mpyui, op_mpya: sel = mp_y;
      default: sel = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
      done   <= 1'b0;
    end else begin
      done <= start;
      if (start) begin
        result <= sel;
      end
    end
  end

  // one-cycle latency.
  a_done_after_start: assert property (
    @(posedge clk) disable iff (rst) start |=> done
  );

endmodule

/* spu_alu.f */
+incdir+.
spu_alu_pkg.sv
fp_lane.sv
mpy_lane.sv
sp_alu.sv
spu_alu_wb.sv
tb_spu_alu.sv

/* spu_alu_pkg.sv */
`include "spu_alu_settings.svh"

package spu_alu_pkg;

  typedef enum logic [3:0] {
    op_nop   = 4'd0,
    op_fa    = 4'd1,
    op_fs    = 4'd2,
    op_fm    = 4'd3,
    op_fma   = 4'd4,
    op_fms   = 4'd5,
    op_fnms  = 4'd6,
    op_mpy   = 4'd7,
    op_mpyu  = 4'd8,
    op_mpyh  = 4'd9,
    op_mpyi  = 4'd10,
    op_mpyui = 4'd11,
    op_mpya  = 4'd12
  } op_e;

  // slot 0 sits in the low word.
  typedef logic [`SPU_QUAD_W/`SPU_WORD_W-1:0][`SPU_WORD_W-1:0] quad_t;

  typedef struct packed {
    op_e        op;
    quad_t      ra;
    quad_t      rb;
    quad_t      rc;
    logic [9:0] imm10;
  } alu_req_t;

  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [`SPU_WB_ADR_W-1:0] adr;
    logic [`SPU_WORD_W-1:0]   dat;
  } wb_m2s_t;

  typedef struct packed {
    logic                   ack;
    logic [`SPU_WORD_W-1:0] dat;
  } wb_s2m_t;

endpackage

/* spu_alu_settings.svh */
`ifndef SPU_ALU_SETTINGS_SVH
`define SPU_ALU_SETTINGS_SVH

// datapath widths.
`define SPU_QUAD_W   128
`define SPU_WORD_W   32
`define SPU_SLOTS    4

// wishbone word address width.
`define SPU_WB_ADR_W 5

// register map, quadword bases hold four words, slot 0 first.
`define SPU_ADR_RA   5'd0
`define SPU_ADR_RB   5'd4
`define SPU_ADR_RC   5'd8
`define SPU_ADR_CMD  5'd12
`define SPU_ADR_STAT 5'd13
`define SPU_ADR_RES  5'd16

`define SPU_TIMEOUT  200

`endif

/* spu_alu_wb.sv */
`timescale 1ns/1ps
`include "spu_alu_settings.svh"

module spu_alu_wb
  import spu_alu_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  wb_m2s_t wb_in,
  output wb_s2m_t wb_out
);

  logic                     ack;
  logic                     req_acc;
  logic                     wr_acc;
  logic                     cmd_wr;
  logic                     start;
  logic                     ready;
  logic                     done;
  logic [1:0]               slot;
  logic [`SPU_WB_ADR_W-1:0] adr_base;
  logic [`SPU_WORD_W-1:0]   rd_dat;
  quad_t                    ra_q;
  quad_t                    rb_q;
  quad_t                    rc_q;
  quad_t                    result;
  alu_req_t                 req;

  assign req_acc  = wb_in.cyc && wb_in.stb && !ack;
  assign wr_acc   = req_acc && wb_in.we;
  assign cmd_wr   = wr_acc && (wb_in.adr == `SPU_ADR_CMD);
  assign slot     = wb_in.adr[1:0];
  assign adr_base = {wb_in.adr[`SPU_WB_ADR_W-1:2], 2'b00};

  ////////////////////////////////////////////////////////////
  // bus handshake and register writes.
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      ack   <= 1'b0;
      start <= 1'b0;
      ready <= 1'b0;
      ra_q  <= '0;
      rb_q  <= '0;
      rc_q  <= '0;
      req   <= '0;
    end else begin
      ack   <= req_acc;
      start <= cmd_wr;
      if (wr_acc) begin
        case (adr_base)
          `SPU_ADR_RA: ra_q[slot] <= wb_in.dat;
          `SPU_ADR_RB: rb_q[slot] <= wb_in.dat;
          `SPU_ADR_RC: rc_q[slot] <= wb_in.dat;
          default: ;
        endcase
      end
      if (cmd_wr) begin
        req   <= '{op: op_e'(wb_in.dat[3:0]), ra: ra_q, rb: rb_q, rc: rc_q,
                   imm10: wb_in.dat[13:4]};
        ready <= 1'b0;
      end else if (done) begin
        ready <= 1'b1;
      end
    end
  end

  // read data follows the held address.
  always_comb begin
    case (adr_base)
      `SPU_ADR_RA:  rd_dat = ra_q[slot];
      `SPU_ADR_RB:  rd_dat = rb_q[slot];
      `SPU_ADR_RC:  rd_dat = rc_q[slot];
      `SPU_ADR_RES: rd_dat = result[slot];
      default:      rd_dat = '0;
    endcase
    if (wb_in.adr == `SPU_ADR_STAT) rd_dat = {31'd0, ready};
  end

  assign wb_out.ack = ack;
  assign wb_out.dat = rd_dat;

  sp_alu u_alu (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .req    (req),
    .result (result),
    .done   (done)
  );

  a_ack_single: assert property (@(posedge clk) disable iff (rst) ack |=> !ack);
  a_ack_in_cycle: assert property (
    @(posedge clk) disable iff (rst) ack |-> (wb_in.cyc && wb_in.stb)
  );

endmodule

/* tb_spu_alu.sv */
`timescale 1ns/1ps
`include "spu_alu_settings.svh"

module tb_spu_alu
  import spu_alu_pkg::*;
();

  logic    clk = 1'b0;
  logic    rst;
  wb_m2s_t m2s;
  wb_s2m_t s2m;
  integer  seed;
  int      errors;
  int      timeouts;

  // operand words as the host last wrote them.
  logic [31:0] ra_w [4];
  logic [31:0] rb_w [4];
  logic [31:0] rc_w [4];

  always #10 clk = ~clk;

  spu_alu_wb spu_alu_wb_i (
    .clk    (clk),
    .rst    (rst),
    .wb_in  (m2s),
    .wb_out (s2m)
  );

  ////////////////////////////////////////////////////////////
  // bus access.
  ////////////////////////////////////////////////////////////
  task automatic bus_cycle(input logic we, input logic [`SPU_WB_ADR_W-1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    int n;
    rdat = '0;
    n    = 0;
    @(negedge clk);
    m2s = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    do begin
      @(negedge clk);
      n++;
    end while (!s2m.ack && n < `SPU_TIMEOUT);
    if (s2m.ack) begin
      rdat = s2m.dat;
      // request stays up until ack has fallen.
      @(negedge clk);
    end else begin
      $display("timeout at %0t: no ack for bus access to address %0d", $time, adr);
      timeouts++;
    end
    m2s = '0;
  endtask

  task automatic wb_write(input logic [`SPU_WB_ADR_W-1:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [`SPU_WB_ADR_W-1:0] adr, output logic [31:0] dat);
    bus_cycle(1'b0, adr, 32'd0, dat);
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model.
  ////////////////////////////////////////////////////////////
  function automatic logic [23:0] mantissa_of(logic [31:0] w);
    return (w[30:23] == 8'd0) ? 24'd0 : {1'b1, w[22:0]};
  endfunction

  function automatic logic [31:0] ref_mpy(op_e op, logic [31:0] a, b, c, logic [9:0] imm);
    longint sa;
    longint sb;
    longint ua;
    longint ub;
    longint ha;
    longint si;
    longint ui;
    sa = longint'($signed(a[15:0]));
    sb = longint'($signed(b[15:0]));
    ua = longint'(a[15:0]);
    ub = longint'(b[15:0]);
    ha = longint'(a[31:16]);
    si = longint'($signed(imm));
    ui = si & 64'hffff;
    case (op)
      op_mpy:   return 32'(sa * sb);
      op_mpyu:  return 32'(ua * ub);
      op_mpyh:  return 32'((ha * ub) << 16);
      op_mpyi:  return 32'(sa * si);
      op_mpyui: return 32'(ua * ui);
      op_mpya:  return 32'(sa * sb + longint'(c));
      default:  return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] ref_fp(op_e op, logic [31:0] a, b, c);
    logic         mul;
    logic [31:0]  d;
    logic [639:0] pm;
    logic [639:0] qm;
    logic [639:0] sm;
    logic         ps;
    logic         qs;
    logic         rs;
    int           pe;
    int           qe;
    int           lead;
    int           ex;
    mul = op inside {op_fm, op_fma, op_fms, op_fnms};
    d   = mul ? c : b;
    // each term is m times 2 to the power e.
    if (mul) begin
      pm = 640'(mantissa_of(a)) * 640'(mantissa_of(b));
      pe = int'(a[30:23]) + int'(b[30:23]) - 300;
      ps = a[31] ^ b[31] ^ (op == op_fnms);
    end else begin
      pm = 640'(mantissa_of(a));
      pe = int'(a[30:23]) - 150;
      ps = a[31];
    end
    qm = (op == op_fm) ? 640'd0 : 640'(mantissa_of(d));
    qe = int'(d[30:23]) - 150;
    qs = d[31] ^ ((op == op_fs) || (op == op_fms));
    // common scale of 2^-300 holds every term exactly.
    pm = pm << (pe + 300);
    qm = qm << (qe + 300);
    if (ps == qs) begin
      sm = pm + qm;
      rs = ps;
    end else if (pm >= qm) begin
      sm = pm - qm;
      rs = ps;
    end else begin
      sm = qm - pm;
      rs = qs;
    end
    lead = -1;
    for (int i = 0; i < 640; i++) begin
      if (sm[i]) lead = i;
    end
    ex = lead - 173;
    if (lead < 0 || ex < 1) return 32'd0;
    if (ex > 255) return {rs, 8'hff, 23'h7fffff};
    sm = sm << (639 - lead);
    return {rs, ex[7:0], sm[638:616]};
  endfunction

  function automatic logic [31:0] expected_word(op_e op, logic [9:0] imm, int s);
    if (op inside {op_fa, op_fs, op_fm, op_fma, op_fms, op_fnms}) begin
      return ref_fp(op, ra_w[s], rb_w[s], rc_w[s]);
    end
    return ref_mpy(op, ra_w[s], rb_w[s], rc_w[s], imm);
  endfunction

  function automatic logic [31:0] rand_float(int e_base, int e_span);
    logic [31:0] r;
    int          e;
    r = $random(seed);
    e = e_base + int'($unsigned($random(seed)) % e_span);
    return {r[31], e[7:0], r[22:0]};
  endfunction

  ////////////////////////////////////////////////////////////
  // command and compare.
  ////////////////////////////////////////////////////////////
  task automatic load_ops();
    for (int s = 0; s < 4; s++) begin
      wb_write(`SPU_WB_ADR_W'(`SPU_ADR_RA + s), ra_w[s]);
      wb_write(`SPU_WB_ADR_W'(`SPU_ADR_RB + s), rb_w[s]);
      wb_write(`SPU_WB_ADR_W'(`SPU_ADR_RC + s), rc_w[s]);
    end
  endtask

  task automatic run_op(input op_e op, input logic [9:0] imm, input bit poll);
    logic [31:0] got;
    wb_write(`SPU_ADR_CMD, {18'd0, imm, op});
    if (poll) begin
      wb_read(`SPU_ADR_STAT, got);
      check_word("status", got, 32'd1);
    end
    for (int s = 0; s < 4; s++) begin
      wb_read(`SPU_WB_ADR_W'(`SPU_ADR_RES + s), got);
      check_word($sformatf("res[%0d]", s), got, expected_word(op, imm, s));
    end
  endtask

  initial begin
    logic [31:0] got;
    op_e         int_ops [6];
    logic [9:0]  imms [6];
    int_ops  = '{op_mpy, op_mpyu, op_mpyh, op_mpyi, op_mpyui, op_mpya};
    imms     = '{10'h200, 10'h1ff, 10'h3ff, 10'h000, 10'h001, 10'h2a5};
    seed     = 32'h5a50_2803;
    errors   = 0;
    timeouts = 0;
    rst      = 1'b1;
    m2s      = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // whole map reads zero after reset.
    for (int k = 0; k < 32; k++) begin
      wb_read(`SPU_WB_ADR_W'(k), got);
      check_word($sformatf("reg[%0d]", k), got, 32'd0);
    end
    for (int s = 0; s < 4; s++) begin
      ra_w[s] = $random(seed);
      rb_w[s] = $random(seed);
      rc_w[s] = $random(seed);
    end
    load_ops();
    for (int s = 0; s < 4; s++) begin
      wb_read(`SPU_WB_ADR_W'(`SPU_ADR_RA + s), got);
      check_word($sformatf("ra[%0d]", s), got, ra_w[s]);
      wb_read(`SPU_WB_ADR_W'(`SPU_ADR_RB + s), got);
      check_word($sformatf("rb[%0d]", s), got, rb_w[s]);
      wb_read(`SPU_WB_ADR_W'(`SPU_ADR_RC + s), got);
      check_word($sformatf("rc[%0d]", s), got, rc_w[s]);
    end
    wb_write(`SPU_ADR_RES, 32'hdead_beef);
    wb_write(5'd20, 32'h1234_5678);
    wb_read(`SPU_ADR_RES, got);
    check_word("res[0]", got, 32'd0);
    wb_read(5'd20, got);
    check_word("reg[20]", got, 32'd0);

    ////////////////////////////////////////////////////////////
    // integer multiplies.
    ////////////////////////////////////////////////////////////
    for (int n = 0; n < 6; n++) begin
      for (int s = 0; s < 4; s++) begin
        ra_w[s] = $random(seed);
        rb_w[s] = $random(seed);
        rc_w[s] = $random(seed);
      end
      ra_w[0] = 32'h8000_8000;
      rb_w[0] = 32'h7fff_8000;
      load_ops();
      foreach (int_ops[i]) run_op(int_ops[i], imms[n], 1'b1);
    end

    // add and subtract, slots 1 and 2 cancel on the first pass.
    for (int n = 0; n < 8; n++) begin
      for (int s = 0; s < 4; s++) begin
        ra_w[s] = rand_float(100, 30);
        rb_w[s] = rand_float(100, 30);
      end
      if (n == 0) begin
        rb_w[1] = ra_w[1];
        rb_w[2] = ra_w[2] ^ 32'h8000_0000;
      end
      load_ops();
      run_op(op_fa, 10'd0, 1'b1);
      run_op(op_fs, 10'd0, 1'b1);
    end

    for (int n = 0; n < 8; n++) begin
      for (int s = 0; s < 4; s++) begin
        ra_w[s] = rand_float(97, 60);
        rb_w[s] = rand_float(97, 60);
        rc_w[s] = rand_float(97, 60);
      end
      load_ops();
      run_op(op_fm, 10'd0, 1'b1);
      run_op(op_fma, 10'd0, 1'b1);
      run_op(op_fms, 10'd0, 1'b1);
      run_op(op_fnms, 10'd0, 1'b1);
    end

    // denormal, underflow, overflow both signs.
    ra_w = '{32'h0000_1234, 32'h0500_0000, 32'h7f00_0000, 32'hff00_0000};
    rb_w = '{32'h3f80_0000, 32'h0500_0000, 32'h7f00_0000, 32'h7f00_0000};
    rc_w = '{32'h0000_0001, 32'h0080_0000, 32'h3f80_0000, 32'h8000_0000};
    load_ops();
    run_op(op_fm, 10'd0, 1'b1);
    run_op(op_fa, 10'd0, 1'b1);
    run_op(op_fma, 10'd0, 1'b1);

    // back to back, no status poll.
    for (int s = 0; s < 4; s++) begin
      ra_w[s] = $random(seed);
      rb_w[s] = $random(seed);
      rc_w[s] = $random(seed);
    end
    load_ops();
    run_op(op_mpya, 10'd0, 1'b0);
    run_op(op_mpyh, 10'd0, 1'b0);
    run_op(op_fm, 10'd0, 1'b0);
    run_op(op_mpyi, 10'h3ff, 1'b0);
    run_op(op_nop, 10'd0, 1'b0);

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
